/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := board_io_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/board_io_pkg.sv */
// --------------------
// Board I/O package
// Register port opcodes, register map
// and boot sequencer states
// --------------------

`default_nettype none

`include "board_io_params.svh"

package board_io_pkg;

    // Host register port opcode
    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_op_e;

    // Register map
    typedef enum logic [`REG_ADDR_BITS-1:0] {
        REG_GPIO_OUT = 2'h0,
        REG_GPIO_IN  = 2'h1,    // read only
        REG_START    = 2'h2,
        REG_CONSOLE  = 2'h3
    } reg_addr_e;

    // Boot sequencer
    typedef enum logic [1:0] {
        BOOT_WAIT = 2'd0,
        BOOT_ARM  = 2'd1,
        BOOT_RUN  = 2'd2
    } boot_state_e;

endpackage

`default_nettype wire

/* hdl/board_io_top.sv */
// --------------------
// Board I/O top level
// Key debouncer, register block,
// boot sequencer and pin driver
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "board_io_params.svh"

module board_io_top #(
    parameter int unsigned DEBOUNCE_CYCLES = `DEBOUNCE_CYCLES
) (
    input  wire logic                      clk_100MHz,
    input  wire logic                      pll_locked,

    // Board inputs
    input  wire logic [`NUM_KEYS-1:0]      keys,
    input  wire logic [`NUM_SWITCHES-1:0]  switches,
    input  wire logic                      cpu_txd,
    input  wire logic                      loader_txd,

    // Host register port
    input  wire logic                      reg_valid,
    output logic                           reg_ready,
    input  wire board_io_pkg::reg_op_e     reg_op,
    input  wire board_io_pkg::reg_addr_e   reg_addr,
    input  wire logic [`XLEN-1:0]          reg_wdata,
    output logic                           rd_valid,
    output logic      [`XLEN-1:0]          rd_data,

    // CPU side
    output logic                           key_irq,
    output logic                           cpu_start,
    output logic      [`XLEN-1:0]          cpu_start_addr,

    // Board pins
    output logic                           txd,
    output logic      [`NUM_LEDS-1:0]      led,
    output logic      [7:0]                seg_segments,
    output logic      [3:0]                seg_digits,
    output logic      [2:0]                rgb1,
    output logic      [2:0]                rgb2
);

    logic [`NUM_KEYS-1:0]   keys_db;
    logic [`GPIO_BITS-1:0]  gpio_out;
    logic                   console_sel;
    logic                   start_req;
    logic [`XLEN-1:0]       start_req_addr;

    key_debouncer_bank #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) key_debouncer_bank_inst (
        .clk_100MHz (clk_100MHz),
        .pll_locked (pll_locked),
        .keys       (keys),
        .keys_db    (keys_db),
        .key_irq    (key_irq)
    );

    gpio_regs gpio_regs_inst (
        .clk_100MHz     (clk_100MHz),
        .pll_locked     (pll_locked),
        .reg_valid      (reg_valid),
        .reg_ready      (reg_ready),
        .reg_op         (reg_op),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .keys_db        (keys_db),
        .switches       (switches),
        .gpio_out       (gpio_out),
        .console_sel    (console_sel),
        .start_req      (start_req),
        .start_req_addr (start_req_addr)
    );

    boot_sequencer boot_sequencer_inst (
        .clk_100MHz     (clk_100MHz),
        .pll_locked     (pll_locked),
        .start_req      (start_req),
        .start_req_addr (start_req_addr),
        .cpu_start      (cpu_start),
        .cpu_start_addr (cpu_start_addr)
    );

    board_pin_driver board_pin_driver_inst (
        .clk_100MHz   (clk_100MHz),
        .pll_locked   (pll_locked),
        .gpio_out     (gpio_out),
        .console_sel  (console_sel),
        .cpu_txd      (cpu_txd),
        .loader_txd   (loader_txd),
        .txd          (txd),
        .led          (led),
        .seg_segments (seg_segments),
        .seg_digits   (seg_digits),
        .rgb1         (rgb1),
        .rgb2         (rgb2)
    );

endmodule

`default_nettype wire

/* hdl/board_pin_driver.sv */
// --------------------
// Board pin driver
// GPIO word to LEDs, 7-segment display, RGB LEDs
// and the UART transmit select
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "board_io_params.svh"

module board_pin_driver (
    input  wire logic                   clk_100MHz,
    input  wire logic                   pll_locked,
    input  wire logic [`GPIO_BITS-1:0]  gpio_out,
    input  wire logic                   console_sel,
    input  wire logic                   cpu_txd,
    input  wire logic                   loader_txd,
    output logic                        txd,
    output logic      [`NUM_LEDS-1:0]   led,
    output logic      [7:0]             seg_segments,
    output logic      [3:0]             seg_digits,
    output logic      [2:0]             rgb1,
    output logic      [2:0]             rgb2
);

    // --------------------
    // Display and LEDs
    // --------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            // Segments are active low, all dark
            seg_segments <= '1;
            seg_digits   <= '0;
            led          <= '0;
            rgb1         <= '0;
            rgb2         <= '0;
        end else begin
            // a..g then dp, inverted for the common-anode display
            seg_segments <= ~gpio_out[7:0];
            // Digit 1 on bit 11 down to digit 4 on bit 8
            seg_digits   <= gpio_out[11:8];
            // r, g, b from the high bit down
            rgb1         <= gpio_out[18:16];
            rgb2         <= gpio_out[22:20];
            led          <= gpio_out[31:24];
        end
    end

    // UART transmit, idle high
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            txd <= 1'b1;
        end else if (console_sel) begin
            txd <= loader_txd;
        end else begin
            txd <= cpu_txd;
        end
    end

endmodule

`default_nettype wire

/* hdl/boot_sequencer.sv */
// --------------------
// Boot sequencer
// Automatic start after reset, then
// host-requested starts
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "board_io_params.svh"

module boot_sequencer (
    input  wire logic              clk_100MHz,
    input  wire logic              pll_locked,
    input  wire logic              start_req,
    input  wire logic [`XLEN-1:0]  start_req_addr,
    output logic                   cpu_start,
    output logic      [`XLEN-1:0]  cpu_start_addr
);

    board_io_pkg::boot_state_e state;

    // --------------------
    // Boot FSM
    // --------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            state     <= board_io_pkg::BOOT_WAIT;
            cpu_start <= 1'b0;
        end else begin
            cpu_start <= 1'b0;
            case (state)
                board_io_pkg::BOOT_WAIT: state <= board_io_pkg::BOOT_ARM;
                board_io_pkg::BOOT_ARM: begin
                    // One automatic start on the way into run
                    state     <= board_io_pkg::BOOT_RUN;
                    cpu_start <= 1'b1;
                end
                board_io_pkg::BOOT_RUN:  cpu_start <= start_req;
                default:                 state <= board_io_pkg::BOOT_WAIT;
            endcase
        end
    end

    // Address travels with the pulse
    always_ff @(posedge clk_100MHz) begin
        if (state == board_io_pkg::BOOT_ARM) begin
            cpu_start_addr <= `DEFAULT_START_ADDR;
        end else if (start_req) begin
            cpu_start_addr <= start_req_addr;
        end
    end

endmodule

`default_nettype wire

/* hdl/gpio_regs.sv */
// --------------------
// Host register block
// Valid/ready port, GPIO output word, start request,
// console select and registered read path
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "board_io_params.svh"

module gpio_regs (
    input  wire logic                      clk_100MHz,
    input  wire logic                      pll_locked,
    input  wire logic                      reg_valid,
    output logic                           reg_ready,
    input  wire board_io_pkg::reg_op_e     reg_op,
    input  wire board_io_pkg::reg_addr_e   reg_addr,
    input  wire logic [`XLEN-1:0]          reg_wdata,
    output logic                           rd_valid,
    output logic      [`XLEN-1:0]          rd_data,
    input  wire logic [`NUM_KEYS-1:0]      keys_db,
    input  wire logic [`NUM_SWITCHES-1:0]  switches,
    output logic      [`GPIO_BITS-1:0]     gpio_out,
    output logic                           console_sel,
    output logic                           start_req,
    output logic      [`XLEN-1:0]          start_req_addr
);

    // Accepted request, one stage
    logic                     req_vld;
    logic                     req_wr;
    board_io_pkg::reg_addr_e  req_addr;
    logic [`XLEN-1:0]         req_wdata;

    logic [`GPIO_BITS-1:0]    gpio_in;
    logic                     accept;

    assign accept = reg_valid & reg_ready;

    // Pressed keys read as 1, switches in the second byte
    assign gpio_in = {{(`GPIO_BITS - 8 - `NUM_SWITCHES){1'b0}}, switches,
                      {(8 - `NUM_KEYS){1'b0}}, ~keys_db};

    // --------------------
    // Accept stage
    // --------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            reg_ready <= 1'b0;
            req_vld   <= 1'b0;
            req_wr    <= 1'b0;
        end else begin
            // Opens one cycle after reset and stays open
            reg_ready <= 1'b1;
            req_vld   <= accept;
            req_wr    <= (reg_op == board_io_pkg::REG_WRITE);
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (accept) begin
            req_addr  <= reg_addr;
            req_wdata <= reg_wdata;
        end
    end

    // --------------------
    // Register update
    // --------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            gpio_out       <= '0;
            console_sel    <= 1'b0;
            start_req      <= 1'b0;
            start_req_addr <= `DEFAULT_START_ADDR;
            rd_valid       <= 1'b0;
        end else begin
            start_req <= 1'b0;
            rd_valid  <= req_vld & ~req_wr;
            if (req_vld && req_wr) begin
                case (req_addr)
                    board_io_pkg::REG_GPIO_OUT: gpio_out <= req_wdata;
                    board_io_pkg::REG_START: begin
                        start_req      <= 1'b1;
                        start_req_addr <= req_wdata;
                    end
                    board_io_pkg::REG_CONSOLE:  console_sel <= req_wdata[0];
                    default: ;  // input word ignores writes
                endcase
            end
        end
    end

    // Read data mux
    always_ff @(posedge clk_100MHz) begin
        if (req_vld && !req_wr) begin
            case (req_addr)
                board_io_pkg::REG_GPIO_OUT: rd_data <= gpio_out;
                board_io_pkg::REG_GPIO_IN:  rd_data <= gpio_in;
                board_io_pkg::REG_START:    rd_data <= start_req_addr;
                default:                    rd_data <= {{(`XLEN - 1){1'b0}}, console_sel};
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/key_debouncer_bank.sv */
// --------------------
// Key debouncer bank
// Input synchronizer, per-key stability counters
// and the key-pressed interrupt
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "board_io_params.svh"

module key_debouncer_bank #(
    parameter int unsigned DEBOUNCE_CYCLES = `DEBOUNCE_CYCLES
) (
    input  wire logic                  clk_100MHz,
    input  wire logic                  pll_locked,
    input  wire logic [`NUM_KEYS-1:0]  keys,
    output logic      [`NUM_KEYS-1:0]  keys_db,
    output logic                       key_irq
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    // Two-flop synchronizer, keys idle high
    logic [`NUM_KEYS-1:0] keys_meta;
    logic [`NUM_KEYS-1:0] keys_sync;

    // One stability counter per key
    logic [CNT_W-1:0] stable_cnt [`NUM_KEYS];

    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            keys_meta <= '1;
            keys_sync <= '1;
        end else begin
            keys_meta <= keys;
            keys_sync <= keys_meta;
        end
    end

    // --------------------
    // Stability counters
    // --------------------
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            keys_db <= '1;
            for (int i = 0; i < `NUM_KEYS; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_KEYS; i++) begin
                if (keys_sync[i] == keys_db[i]) begin
                    // Level agrees, start over
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    // Held long enough, take the new level
                    keys_db[i]    <= keys_sync[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Interrupt while any key is held down
    always_ff @(posedge clk_100MHz, negedge pll_locked) begin
        if (!pll_locked) begin
            key_irq <= 1'b0;
        end else begin
            key_irq <= ~(&keys_db);
        end
    end

endmodule

`default_nettype wire

/* include/board_io_params.svh */
// --------------------
// Board I/O parameters
// Word widths, pin counts, boot address
// and key debounce time
// --------------------

`ifndef BOARD_IO_PARAMS_SVH
`define BOARD_IO_PARAMS_SVH

// Data and address word width
`define XLEN                32

// GPIO output and input word width
`define GPIO_BITS           32

// Board pin counts
`define NUM_KEYS            5
`define NUM_SWITCHES        8
`define NUM_LEDS            8

// Stable cycles before a key level is taken, 1 ms at 100 MHz
`define DEBOUNCE_CYCLES     100000

// Address of the first instruction after power-up
`define DEFAULT_START_ADDR  32'h8000_0000

// Register select width on the host port
`define REG_ADDR_BITS       2

`endif

/* src.f */
+incdir+include
hdl/board_io_pkg.sv
hdl/key_debouncer_bank.sv
hdl/gpio_regs.sv
hdl/boot_sequencer.sv
hdl/board_pin_driver.sv
hdl/board_io_top.sv
tb/board_io_tb.sv

/* tb/board_io_tb.sv */
// --------------------
// Board I/O testbench
// Clock, reset, host register traffic,
// reference model, compare task and report
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "board_io_params.svh"

module board_io_tb;

    localparam int TB_DEBOUNCE = 16;
    localparam int WAIT_LIMIT  = 64;

    logic                        clk_100MHz;
    logic                        pll_locked;
    logic [`NUM_KEYS-1:0]        keys;
    logic [`NUM_SWITCHES-1:0]    switches;
    logic                        cpu_txd;
    logic                        loader_txd;
    logic                        reg_valid;
    logic                        reg_ready;
    board_io_pkg::reg_op_e       reg_op;
    board_io_pkg::reg_addr_e     reg_addr;
    logic [`XLEN-1:0]            reg_wdata;
    logic                        rd_valid;
    logic [`XLEN-1:0]            rd_data;
    logic                        key_irq;
    logic                        cpu_start;
    logic [`XLEN-1:0]            cpu_start_addr;
    logic                        txd;
    logic [`NUM_LEDS-1:0]        led;
    logic [7:0]                  seg_segments;
    logic [3:0]                  seg_digits;
    logic [2:0]                  rgb1;
    logic [2:0]                  rgb2;

    // Scoreboard counters
    int          checks     = 0;
    int          errors     = 0;
    int          test_mark  = 0;
    logic [31:0] lfsr_state = 32'd77;

    // txd checker state
    logic txd_check_en  = 1'b0;
    logic txd_check_sel = 1'b0;
    logic txd_prev_ok   = 1'b0;
    logic txd_prev_src  = 1'b1;

    board_io_top #(
        .DEBOUNCE_CYCLES (TB_DEBOUNCE)
    ) board_io_top_inst (
        .clk_100MHz     (clk_100MHz),
        .pll_locked     (pll_locked),
        .keys           (keys),
        .switches       (switches),
        .cpu_txd        (cpu_txd),
        .loader_txd     (loader_txd),
        .reg_valid      (reg_valid),
        .reg_ready      (reg_ready),
        .reg_op         (reg_op),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .key_irq        (key_irq),
        .cpu_start      (cpu_start),
        .cpu_start_addr (cpu_start_addr),
        .txd            (txd),
        .led            (led),
        .seg_segments   (seg_segments),
        .seg_digits     (seg_digits),
        .rgb1           (rgb1),
        .rgb2           (rgb2)
    );

    // 100 MHz clock
    initial begin
        clk_100MHz = 1'b0;
        forever #5 clk_100MHz = ~clk_100MHz;
    end

    // --------------------
    // Random source and reference model
    // --------------------

    // Right-shifting Galois LFSR, 32 bits
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Pins packed as led, segments, digits, rgb1, rgb2
    function automatic logic [25:0] map_pins(input logic [31:0] gpio);
        logic [7:0] segs;
        logic [2:0] c1;
        logic [2:0] c2;
        // Active-low segments
        segs = ~gpio[7:0];
        // RGB fields with red in the top bit
        c1 = gpio[18:16];
        c2 = gpio[22:20];
        return {gpio[31:24], segs, gpio[11:8], c1, c2};
    endfunction

    // Pressed keys in the low byte, switches in the second
    function automatic logic [31:0] input_word(input logic [`NUM_KEYS-1:0] pressed,
                                               input logic [`NUM_SWITCHES-1:0] sw);
        return {16'h0000, sw, {(8 - `NUM_KEYS){1'b0}}, pressed};
    endfunction

    // --------------------
    // Compare and report
    // --------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        if (errors == test_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    task automatic verify_reset_outputs();
        check_value("reg_ready", 32'(reg_ready), 32'd0);
        check_value("rd_valid", 32'(rd_valid), 32'd0);
        check_value("cpu_start", 32'(cpu_start), 32'd0);
        check_value("key_irq", 32'(key_irq), 32'd0);
        check_value("txd", 32'(txd), 32'd1);
        check_value("seg_segments", 32'(seg_segments), 32'hff);
        check_value("seg_digits", 32'(seg_digits), 32'd0);
        check_value("led", 32'(led), 32'd0);
        check_value("rgb1", 32'(rgb1), 32'd0);
        check_value("rgb2", 32'(rgb2), 32'd0);
    endtask

    // txd follows the selected source one cycle late
    always @(negedge clk_100MHz) begin
        if (txd_prev_ok) begin
            check_value("txd", 32'(txd), 32'(txd_prev_src));
        end
        txd_prev_src = txd_check_sel ? loader_txd : cpu_txd;
        txd_prev_ok  = txd_check_en;
    end

    // --------------------
    // Host port tasks
    // --------------------

    // Returns right after the acceptance edge
    task automatic host_transfer(input board_io_pkg::reg_op_e op,
                                 input board_io_pkg::reg_addr_e addr,
                                 input logic [31:0] wdata);
        int waited;
        waited = 0;
        @(posedge clk_100MHz);
        reg_valid <= 1'b1;
        reg_op    <= op;
        reg_addr  <= addr;
        reg_wdata <= wdata;
        @(negedge clk_100MHz);
        while (!reg_ready && waited < WAIT_LIMIT) begin
            @(negedge clk_100MHz);
            waited++;
        end
        if (!reg_ready) begin
            errors++;
            $display("Register port stayed not ready");
        end
        @(posedge clk_100MHz);
        reg_valid <= 1'b0;
    endtask

    task automatic write_register(input board_io_pkg::reg_addr_e addr,
                                  input logic [31:0] wdata);
        host_transfer(board_io_pkg::REG_WRITE, addr, wdata);
    endtask

    task automatic read_register(input board_io_pkg::reg_addr_e addr,
                                 output logic [31:0] data);
        int waited;
        waited = 0;
        data = '0;
        host_transfer(board_io_pkg::REG_READ, addr, '0);
        @(negedge clk_100MHz);
        while (!rd_valid && waited < WAIT_LIMIT) begin
            @(negedge clk_100MHz);
            waited++;
        end
        if (rd_valid) begin
            data = rd_data;
            // Single-cycle strobe
            @(negedge clk_100MHz);
            check_value("rd_valid", 32'(rd_valid), 32'd0);
        end else begin
            errors++;
            $display("Read data never came back from the register port");
        end
    endtask

    task automatic wait_for_irq(input logic level);
        int waited;
        waited = 0;
        @(negedge clk_100MHz);
        while (key_irq !== level && waited < WAIT_LIMIT) begin
            @(negedge clk_100MHz);
            waited++;
        end
        if (key_irq !== level) begin
            errors++;
            $display("Key interrupt did not reach level %0d in time", level);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0]              word;
        logic [31:0]              rd;
        logic [25:0]              pins;
        logic [`NUM_KEYS-1:0]     pressed;
        logic [`NUM_SWITCHES-1:0] sw;
        int                       key;
        int                       pulses;
        int                       first_pulse;
        int                       tries;

        pll_locked = 1'b0;
        keys       = '1;
        switches   = '0;
        cpu_txd    = 1'b1;
        loader_txd = 1'b1;
        reg_valid  = 1'b0;
        reg_op     = board_io_pkg::REG_READ;
        reg_addr   = board_io_pkg::REG_GPIO_OUT;
        reg_wdata  = '0;

        // Reset outputs, held through the first cycle after release
        repeat (7) @(posedge clk_100MHz);
        @(negedge clk_100MHz);
        verify_reset_outputs();
        @(posedge clk_100MHz);
        pll_locked <= 1'b1;
        @(negedge clk_100MHz);
        verify_reset_outputs();
        pulses      = 0;
        first_pulse = -1;
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk_100MHz);
            if (cpu_start) begin
                pulses++;
                if (first_pulse < 0) begin
                    first_pulse = i;
                end
                check_value("cpu_start_addr", cpu_start_addr, `DEFAULT_START_ADDR);
            end
        end
        check_value("boot pulses", pulses, 1);
        if (first_pulse < 1 || first_pulse > 4) begin
            errors++;
            $display("Boot start pulse did not come within four cycles of reset release");
        end
        report_test("reset and boot");

        // Pins two edges after acceptance
        for (int i = 0; i < 8; i++) begin
            word = random_bits(32);
            write_register(board_io_pkg::REG_GPIO_OUT, word);
            repeat (2) @(posedge clk_100MHz);
            @(negedge clk_100MHz);
            pins = map_pins(word);
            check_value("led", 32'(led), 32'(pins[25:18]));
            check_value("seg_segments", 32'(seg_segments), 32'(pins[17:10]));
            check_value("seg_digits", 32'(seg_digits), 32'(pins[9:6]));
            check_value("rgb1", 32'(rgb1), 32'(pins[5:3]));
            check_value("rgb2", 32'(rgb2), 32'(pins[2:0]));
            read_register(board_io_pkg::REG_GPIO_OUT, rd);
            check_value("rd_data", rd, word);
        end
        report_test("gpio output mapping");

        // One key held, switches random
        word    = random_bits(`NUM_SWITCHES);
        sw      = word[`NUM_SWITCHES-1:0];
        key     = random_bits(3) % `NUM_KEYS;
        pressed = '0;
        pressed[key] = 1'b1;
        @(posedge clk_100MHz);
        switches <= sw;
        keys     <= ~pressed;
        tries = 0;
        rd    = '0;
        while (rd[key] !== 1'b1 && tries < WAIT_LIMIT) begin
            read_register(board_io_pkg::REG_GPIO_IN, rd);
            tries++;
        end
        if (rd[key] !== 1'b1) begin
            errors++;
            $display("Pressed key %0d never showed up in the input word", key);
        end
        check_value("gpio_in", rd, input_word(pressed, sw));
        // Release glitch shorter than the debounce time
        @(posedge clk_100MHz);
        keys <= '1;
        repeat (TB_DEBOUNCE / 2) @(posedge clk_100MHz);
        keys <= ~pressed;
        for (int i = 0; i < 6; i++) begin
            read_register(board_io_pkg::REG_GPIO_IN, rd);
            check_value("gpio_in", rd, input_word(pressed, sw));
        end
        report_test("input readback and debounce");

        // Interrupt follows sustained press and release
        @(posedge clk_100MHz);
        keys <= '1;
        wait_for_irq(1'b0);
        word    = random_bits(`NUM_KEYS);
        pressed = word[`NUM_KEYS-1:0];
        if (pressed == '0) begin
            pressed[0] = 1'b1;
        end
        @(posedge clk_100MHz);
        keys <= ~pressed;
        wait_for_irq(1'b1);
        @(posedge clk_100MHz);
        keys <= '1;
        wait_for_irq(1'b0);
        report_test("key interrupt");

        // Start pulse two edges after acceptance
        word = random_bits(32);
        write_register(board_io_pkg::REG_START, word);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk_100MHz);
            check_value("cpu_start", 32'(cpu_start), (i == 2) ? 32'd1 : 32'd0);
            if (cpu_start) begin
                check_value("cpu_start_addr", cpu_start_addr, word);
            end
        end
        read_register(board_io_pkg::REG_START, rd);
        check_value("rd_data", rd, word);
        report_test("start request");

        // Both console sources with random bit patterns
        for (int sel = 0; sel < 2; sel++) begin
            write_register(board_io_pkg::REG_CONSOLE, 32'(sel));
            read_register(board_io_pkg::REG_CONSOLE, rd);
            check_value("console", rd, 32'(sel));
            @(posedge clk_100MHz);
            txd_check_sel = sel[0];
            txd_check_en  = 1'b1;
            for (int i = 0; i < 32; i++) begin
                word = random_bits(2);
                cpu_txd    <= word[0];
                loader_txd <= word[1];
                @(posedge clk_100MHz);
            end
            txd_check_en = 1'b0;
        end
        report_test("console select");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
